// File: filelist.f
+incdir+design
design/thor_pkg.sv
design/insn_win_if.sv
design/imm_dec_if.sv
design/insn_window.sv
design/thor_decode_imm.sv
design/issue_ctrl.sv
design/imm_decode_top.sv
test/imm_decode_properties.sv
test/tb_imm_decode.sv

// File: test/tb_imm_decode.sv
// ==========================================================================
// Immediate decode slice testbench
// Directed streams of short, wide and prefixed forms checked per record
// ==========================================================================

`include "thor_defs.svh"

module tb_imm_decode import thor_pkg::*; ();

localparam code_word_t NOP_WORD = 32'h0000_007F;

logic        clk;
logic        rst;
logic        word_wr;
code_word_t  word;
logic        full;
logic        dec_valid;
stream_ofs_t dec_ofs;
insn_len_t   dec_len;
imm_t        imma, immb, immc, immd;

code_word_t  stim[$];                              // Words of the stream
insn_len_t   exp_len[$];
imm_t        exp_a[$], exp_b[$], exp_c[$], exp_d[$];
insn_len_t   got_len[$];                           // Filled by the monitor
stream_ofs_t got_ofs[$];
imm_t        got_a[$], got_b[$], got_c[$], got_d[$];
logic        full_seen;
logic [31:0] lfsr = 32'd38;
int          errors = 0;
int          n_tests = 0;
int          n_failed = 0;

imm_decode_top i_dut (
	.clk (clk), .rst (rst), .word_wr (word_wr), .word (word), .full (full),
	.dec_valid (dec_valid), .dec_ofs (dec_ofs), .dec_len (dec_len),
	.imma (imma), .immb (immb), .immc (immc), .immd (immd)
);

initial clk = 1'b0;
always #10 clk = ~clk;

// Collects each issued record on the falling edge
always @(negedge clk) begin
	if (!rst && dec_valid) begin
		got_len.push_back(dec_len);
		got_ofs.push_back(dec_ofs);
		got_a.push_back(imma);
		got_b.push_back(immb);
		got_c.push_back(immc);
		got_d.push_back(immd);
	end
	if (!rst && full)
		full_seen = 1'b1;
end

// ==========================================================================
// Random bits and expected-value rules
// ==========================================================================

// Galois LFSR stepped once per bit with bits landing in the low n positions
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		r = {r[30:0], lfsr[0]};
	end
	return r;
endfunction

// Sign bit of the field copied up and low bits kept if wider
function automatic imm_t sext_field(input logic [63:0] f, input int width);
	imm_t r;
	for (int i = 0; i < `THOR_IMM_WID; i++)
		r[i] = (i < width) ? f[i] : f[width-1];
	return r;
endfunction

task automatic expect_insn(input insn_len_t len, input imm_t a, b, c, d);
	exp_len.push_back(len);
	exp_a.push_back(a);
	exp_b.push_back(b);
	exp_c.push_back(c);
	exp_d.push_back(d);
endtask

// One-word forms 04, 40 and 34
task automatic add_short(input opcode_t op);
	code_word_t w;
	w = rand_bits(24) << 8;
	w[7:0] = op;
	stim.push_back(w);
	case (op)
	8'h04:   expect_insn(6'd4, '0, sext_field(w[26:17], 10), '0, '0);
	8'h40:   expect_insn(6'd4, '0, sext_field(w[26:19], 8), '0, '0);
	default: expect_insn(6'd4, sext_field(w[31:7], 25), '0, '0, '0);
	endcase
endtask

// Two-word forms 4F and 07 with bit numbers spanning both words
task automatic add_wide(input opcode_t op);
	code_word_t  w0;
	code_word_t  w1;
	logic [63:0] p;
	w0 = rand_bits(24) << 8;
	w0[7:0] = op;
	w1 = rand_bits(32);
	p  = {w1, w0};
	stim.push_back(w0);
	stim.push_back(w1);
	if (op == 8'h4F)
		expect_insn(6'd8, '0, '0, sext_field(p[48:25], 24), '0);
	else
		expect_insn(6'd8, sext_field({p[53:31], p[16:12]}, 28), imm_t'(p[30:17]), '0, '0);
endtask

// Opcode 04 then PFX22 or PFX54 aimed at one slot
task automatic add_prefixed(input logic [1:0] sel, input logic long_pfx);
	code_word_t w;
	code_word_t p0;
	code_word_t p1;
	imm_t       e[4];
	w = rand_bits(24) << 8;
	w[7:0] = 8'h04;
	e[0] = '0;
	e[1] = sext_field(w[26:17], 10);
	e[2] = '0;
	e[3] = '0;
	p0 = rand_bits(22) << 10;
	p0[9:8] = sel;
	p0[7:0] = long_pfx ? 8'hFC : 8'h7C;
	stim.push_back(w);
	stim.push_back(p0);
	if (long_pfx) begin
		p1 = rand_bits(32);
		stim.push_back(p1);
		e[sel] = imm_t'({p1, p0} >> 10);          // Low 32 of 54-bit payload
		expect_insn(6'd12, e[0], e[1], e[2], e[3]);
	end
	else begin
		e[sel] = imm_t'(p0[31:10]);
		expect_insn(6'd8, e[0], e[1], e[2], e[3]);
	end
endtask

// ==========================================================================
// Compare tasks
// ==========================================================================

task automatic check_imm(input string what, input imm_t got, input imm_t exp);
	if (got !== exp) begin
		$display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
		errors++;
	end
endtask

task automatic check_len(input string what, input insn_len_t got, input insn_len_t exp);
	if (got !== exp) begin
		$display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
		errors++;
	end
endtask

task automatic check_ofs(input string what, input stream_ofs_t got, input stream_ofs_t exp);
	if (got !== exp) begin
		$display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
		errors++;
	end
endtask

// ==========================================================================
// Stimulus
// ==========================================================================

task automatic apply_reset();
	@(posedge clk);
	rst     <= 1'b1;
	word_wr <= 1'b0;
	repeat (3) @(posedge clk);
	got_len.delete();
	got_ofs.delete();
	got_a.delete();
	got_b.delete();
	got_c.delete();
	got_d.delete();
	full_seen = 1'b0;
	rst <= 1'b0;
endtask

// One word per cycle and held back while the queue is full
task automatic send_word(input code_word_t w);
	int t;
	t = 0;
	@(posedge clk);
	while (full && t < 200) begin
		word_wr <= 1'b0;
		@(posedge clk);
		t++;
	end
	if (t >= 200) begin
		$display("timeout: queue stayed full at %0t", $time);
		errors++;
	end
	word_wr <= 1'b1;
	word    <= w;
endtask

// Pads with NOPs, waits for all records and compares them in order
task automatic run_stream(input string name);
	stream_ofs_t ofs;
	int          n;
	int          t;
	int          err0;
	err0 = errors;
	foreach (stim[i])
		send_word(stim[i]);
	for (int i = 0; i < 8; i++)
		send_word(NOP_WORD);
	@(posedge clk);
	word_wr <= 1'b0;
	expect_insn(6'd4, '0, '0, '0, '0);  // One pad NOP issues and 28 bytes stay
	n = exp_len.size();
	t = 0;
	while (got_len.size() < n && t < 400) begin
		@(posedge clk);
		t++;
	end
	if (got_len.size() < n) begin
		$display("timeout: %s got %0d of %0d records", name, got_len.size(), n);
		errors++;
	end
	t = 0;
	while (t < 8) begin  // Quiet window for extra records
		@(posedge clk);
		t++;
	end
	if (got_len.size() > n) begin
		$display("%s issued %0d records where %0d were due", name, got_len.size(), n);
		errors++;
	end
	// Issue pops at least four bytes per cycle so count stays far from 61
	if (full_seen) begin
		$display("%s raised full although issue kept pace", name);
		errors++;
	end
	ofs = '0;
	for (int i = 0; i < n && i < got_len.size(); i++) begin
		check_ofs($sformatf("%s rec %0d ofs", name, i), got_ofs[i], ofs);
		check_len($sformatf("%s rec %0d len", name, i), got_len[i], exp_len[i]);
		check_imm($sformatf("%s rec %0d imma", name, i), got_a[i], exp_a[i]);
		check_imm($sformatf("%s rec %0d immb", name, i), got_b[i], exp_b[i]);
		check_imm($sformatf("%s rec %0d immc", name, i), got_c[i], exp_c[i]);
		check_imm($sformatf("%s rec %0d immd", name, i), got_d[i], exp_d[i]);
		ofs = ofs + stream_ofs_t'(exp_len[i]);  // Sum of earlier lengths
	end
	n_tests++;
	if (errors == err0) begin
		$display("test %s passed, %0d records", name, n);
	end
	else begin
		n_failed++;
		$display("test %s failed, %0d errors", name, errors - err0);
	end
	stim.delete();
	exp_len.delete();
	exp_a.delete();
	exp_b.delete();
	exp_c.delete();
	exp_d.delete();
endtask

// ==========================================================================
// Directed tests
// ==========================================================================

task automatic test_short_forms();
	apply_reset();
	for (int i = 0; i < 6; i++)
		add_short(i[0] ? 8'h40 : 8'h04);
	run_stream("short_forms");
endtask

task automatic test_wide_forms();
	apply_reset();
	add_short(8'h34);
	add_wide(8'h4F);
	add_wide(8'h07);
	add_short(8'h34);
	add_wide(8'h07);
	add_wide(8'h4F);
	run_stream("wide_forms");
endtask

task automatic test_prefixes();
	apply_reset();
	for (int s = 0; s < 4; s++)
		add_prefixed(s[1:0], 1'b0);
	add_prefixed(2'd2, 1'b1);
	add_prefixed(2'd0, 1'b1);
	run_stream("prefixes");
endtask

task automatic test_offsets();
	logic [1:0] pick;
	apply_reset();
	for (int i = 0; i < 12; i++) begin
		pick = 2'(rand_bits(2));
		case (pick)
		2'd0:    add_short(8'h04);
		2'd1:    add_short(8'h40);
		2'd2:    add_wide(8'h4F);
		default: add_wide(8'h07);
		endcase
	end
	run_stream("offsets");
endtask

// 15 words back to back against the issue rate
task automatic test_fill_drain();
	apply_reset();
	for (int i = 0; i < 7; i++)
		add_wide(i[0] ? 8'h07 : 8'h4F);
	add_short(8'h04);
	run_stream("fill_drain");
endtask

initial begin
	rst       = 1'b1;
	word_wr   = 1'b0;
	word      = '0;
	full_seen = 1'b0;
	test_short_forms();
	test_wide_forms();
	test_prefixes();
	test_offsets();
	test_fill_drain();
	$display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
	if (errors == 0)
		$display("TEST PASS");
	else
		$display("TEST FAIL");
	$finish;
end

endmodule

// File: test/imm_decode_properties.sv
// ==========================================================================
// Queue and issue assertions
// Watches the byte window link and the record outputs of the slice
// ==========================================================================

`include "thor_defs.svh"

module imm_decode_properties import thor_pkg::*; (
	input logic        clk,
	input logic        rst,
	input byte_count_t count,      // Queue fill
	input logic        pop,
	input logic        full,
	input logic        dec_valid
);

a_count_cap: assert property (@(posedge clk) disable iff (rst)
	count <= byte_count_t'(`THOR_QUEUE_BYTES))
	else $error("queue fill %0d above capacity", count);

// Pops only with a full window
a_pop_level: assert property (@(posedge clk) disable iff (rst)
	pop |-> count >= byte_count_t'(`THOR_WINDOW_BYTES))
	else $error("pop with only %0d bytes queued", count);

a_valid_follows: assert property (@(posedge clk) disable iff (rst)
	pop |=> dec_valid)
	else $error("no record in the cycle after a pop");

a_valid_source: assert property (@(posedge clk) disable iff (rst)
	dec_valid |-> $past(pop))  // Each record has its own pop
	else $error("record without a preceding pop");

a_reset_quiet: assert property (@(posedge clk) rst |=> !dec_valid && !full)
	else $error("record or full active during reset");

endmodule

// Queue link taken from the interface instance in the top
bind imm_decode_top imm_decode_properties i_props (
	.clk       (clk),
	.rst       (rst),
	.count     (i_win_if.count),
	.pop       (i_win_if.pop),
	.full      (full),
	.dec_valid (dec_valid)
);

// File: design/imm_decode_top.sv
// ==========================================================================
// Immediate decode slice
// Code word queue, head decoder and issue stage behind plain ports
// ==========================================================================

module imm_decode_top import thor_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        word_wr,
	input  code_word_t  word,
	output logic        full,
	output logic        dec_valid,
	output stream_ofs_t dec_ofs,
	output insn_len_t   dec_len,
	output imm_t        imma,
	output imm_t        immb,
	output imm_t        immc,
	output imm_t        immd
);

insn_win_if i_win_if ();  // Queue head link
imm_dec_if  i_dec_if ();  // Decode result link

// Byte queue
insn_window i_window (
	.clk     (clk),
	.rst     (rst),
	.word_wr (word_wr),
	.word    (word),
	.full    (full),
	.win     (i_win_if.queue)
);

// Combinational head decode
thor_decode_imm i_decode (
	.win (i_win_if.user),
	.dec (i_dec_if.decoder)
);

// Record issue and pop
issue_ctrl i_issue (
	.clk       (clk),
	.rst       (rst),
	.win       (i_win_if.user),
	.dec       (i_dec_if.issuer),
	.dec_valid (dec_valid),
	.dec_ofs   (dec_ofs),
	.dec_len   (dec_len),
	.imma      (imma),
	.immb      (immb),
	.immc      (immc),
	.immd      (immd)
);

endmodule

// File: design/issue_ctrl.sv
// ==========================================================================
// Issue controller
// Issues one decode record per instruction once the window is full,
// pops its bytes and tracks the stream byte offset
// ==========================================================================

`include "thor_defs.svh"

module issue_ctrl import thor_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	insn_win_if.user    win,
	imm_dec_if.issuer   dec,
	output logic        dec_valid,  // Pulse per record
	output stream_ofs_t dec_ofs,
	output insn_len_t   dec_len,
	output imm_t        imma,
	output imm_t        immb,
	output imm_t        immc,
	output imm_t        immd
);

logic        issue;
stream_ofs_t ofs;  // Offset of the head instruction

// Full window needed so every base form and most prefixes are visible.
// A base plus long prefix can exceed 32 bytes, wait until all are queued.
assign issue = (win.count >= byte_count_t'(`THOR_WINDOW_BYTES)) &&
               (win.count >= byte_count_t'(dec.len));

assign win.pop     = issue;
assign win.pop_len = dec.len;  // Head bytes leave at the same edge

// ==========================================================================
// Control
// ==========================================================================

always_ff @(posedge clk) begin
	if (rst) begin
		dec_valid <= 1'b0;
		ofs       <= '0;
	end
	else begin
		dec_valid <= issue;  // Record valid the cycle after pop
		if (issue)
			ofs <= ofs + stream_ofs_t'(dec.len);
	end
end

// ==========================================================================
// Decode record
// ==========================================================================

always_ff @(posedge clk) begin
	if (issue) begin
		dec_ofs <= ofs;      // Sum of earlier lengths
		dec_len <= dec.len;
		imma    <= dec.imma;
		immb    <= dec.immb;
		immc    <= dec.immc;
		immd    <= dec.immd;
	end
end

endmodule

// File: design/thor_decode_imm.sv
// ==========================================================================
// Immediate decoder
// Combinational decode of the head instruction: base length and up to
// four immediates from the opcode, then an optional trailing constant
// prefix that extends the length and overrides one immediate slot
// ==========================================================================

`include "thor_defs.svh"

module thor_decode_imm import thor_pkg::*; (
	insn_win_if.user   win,  // Window only
	imm_dec_if.decoder dec
);

// Immediate field layouts
localparam logic [4:0]
	F_NONE = 5'd0,
	F_A9   = 5'd1,   // imma 15:7
	F_B10  = 5'd2,   // immb 26:17 signed
	F_CSR  = 5'd3,
	F_A25  = 5'd4,   // imma 31:7 signed
	F_AB   = 5'd5,
	F_A19  = 5'd6,   // PUSH / POP
	F_A51  = 5'd7,
	F_B8   = 5'd8,   // Loads and stores
	F_C24  = 5'd9,   // Indexed forms
	F_B32  = 5'd10,
	F_A12  = 5'd11,  // IRQ
	F_A16  = 5'd12,  // STOP
	F_A15  = 5'd13,  // PFI
	F_A55  = 5'd14,  // REGS
	F_A12R = 5'd15,  // REP
	F_A14  = 5'd16;  // PRED

// Constant prefix codes
localparam opcode_t PFX22  = 8'h7C;
localparam opcode_t PFX54  = 8'hFC;
localparam opcode_t PFX86  = 8'h7D;
localparam opcode_t PFX118 = 8'hFD;
localparam opcode_t PFX150 = 8'h7E;

insn_window_t w;
opcode_t      op;
logic [4:0]   form;
insn_len_t    base;       // Length before any prefix
insn_len_t    pfx_len;    // Zero when no prefix
logic [7:0]   pfx_bits;   // Payload width of the prefix
insn_window_t shifted;
logic [159:0] postfix;    // Bytes after the base instruction
logic [149:0] payload;
imm_t         pfx_val;
imm_t         imma, immb, immc, immd;

// Sign-extend the low n bits of f, wider results keep low bits
function automatic imm_t sext(input logic [63:0] f, input int n);
	logic [63:0] m;
	m = f << (64 - n);
	return imm_t'($signed(m) >>> (64 - n));
endfunction

assign w  = win.window;
assign op = w[7:0];

always_comb begin
	imma = '0;
	immb = '0;
	immc = '0;
	immd = '0;

	// ==================================================================
	// Opcode table
	// ==================================================================
	casez (op)
	8'b?0000000: {base, form} = {6'd4, F_A9};
	8'b?0000100, 8'b?0000101, 8'b?0000110, 8'b?00010??,
	8'b?0001101, 8'b?0001110, 8'b?0010101:
		{base, form} = {6'd4, F_B10};            // Short ALU immediates
	8'b?0000111: {base, form} = {6'd8, F_CSR};
	8'b10100000, 8'b10100001, 8'b10100010, 8'b10100110, 8'b10100111,
	8'b10101???:
		{base, form} = {6'd8, F_NONE};
	8'b?0110100: {base, form} = {6'd4, F_A25};
	8'b?0110101: {base, form} = {6'd4, F_AB};
	8'b0011011?: {base, form} = {6'd4, F_A19};
	8'b1011011?: {base, form} = {6'd8, F_A51};
	8'b?1001111, 8'b?1010111, 8'b?1011111:
		{base, form} = {6'd8, F_C24};            // Must precede the B8 group
	8'b?0111???, 8'b?1000???, 8'b?1001???, 8'b?1010???,
	8'b?1011101, 8'b?1011110:
		{base, form} = {6'd4, F_B8};
	8'b?1100001, 8'b?1101001, 8'b?1101011:
		{base, form} = {6'd8, F_B32};
	8'b?1100011, 8'b?1100111, 8'b?1101000:
		{base, form} = {6'd8, F_NONE};
	8'b?1110000: {base, form} = {6'd4, F_A12};
	8'b?1110001: {base, form} = {6'd4, F_A16};
	8'b?1110011: {base, form} = {6'd4, F_A15};
	8'b?1110101: {base, form} = {6'd8, F_A55};
	8'b?1111000: {base, form} = {6'd4, F_A12R};
	8'b?1111001: {base, form} = {6'd4, F_A14};
	8'b11111100: {base, form} = {6'd8, F_NONE};
	8'b11111101: {base, form} = {6'd16, F_NONE};
	8'b11111110: {base, form} = {6'd20, F_NONE};
	default:     {base, form} = {6'd4, F_NONE};  // NOP 7F and unused
	endcase

	case (form)
	F_A9:  imma = imm_t'(w[15:7]);
	F_B10: immb = sext(w[26:17], 10);
	F_CSR: begin
		imma = sext({w[53:31], w[16:12]}, 28);   // Split field
		immb = imm_t'(w[30:17]);
	end
	F_A25: imma = sext(w[31:7], 25);
	F_AB: begin
		imma = imm_t'(w[11:7]);
		immb = sext(w[31:12], 20);
	end
	F_A19:  imma = imm_t'(w[26:8]);
	F_A51:  imma = imm_t'(w[58:8]);
	F_B8:   immb = sext(w[26:19], 8);
	F_C24:  immc = sext(w[48:25], 24);
	F_B32:  immb = imm_t'(w[48:17]);
	F_A12:  imma = imm_t'(w[18:7]);
	F_A16:  imma = imm_t'(w[26:11]);
	F_A15:  imma = imm_t'(w[26:12]);
	F_A55:  imma = imm_t'(w[63:9]);
	F_A12R: imma = imm_t'(w[25:14]);
	F_A14:  imma = imm_t'(w[25:12]);
	default: ;
	endcase

	// ==================================================================
	// Trailing prefix
	// ==================================================================
	shifted  = w >> {base, 3'b000};  // Bytes past window come in as zero
	postfix  = shifted[159:0];
	pfx_len  = '0;
	pfx_bits = '0;
	case (postfix[7:0])
	PFX22:  {pfx_len, pfx_bits} = {6'd4, 8'd22};
	PFX54:  {pfx_len, pfx_bits} = {6'd8, 8'd54};
	PFX86:  {pfx_len, pfx_bits} = {6'd12, 8'd86};
	PFX118: {pfx_len, pfx_bits} = {6'd16, 8'd118};
	PFX150: {pfx_len, pfx_bits} = {6'd20, 8'd150};
	default: ;
	endcase

	// Payload above the selector, masked to the prefix size
	payload = postfix[159:10] & ({150{1'b1}} >> (8'd150 - pfx_bits));
	pfx_val = imm_t'(payload);  // Low bits kept

	if (pfx_len != '0) begin
		case (postfix[9:8])      // Slot selector
		2'd0: imma = pfx_val;
		2'd1: immb = pfx_val;
		2'd2: immc = pfx_val;
		2'd3: immd = pfx_val;
		endcase
	end
end

assign dec.imma = imma;
assign dec.immb = immb;
assign dec.immc = immc;
assign dec.immd = immd;
assign dec.len  = base + pfx_len;

endmodule

// File: design/insn_window.sv
// ==========================================================================
// Instruction byte queue
// Appends 32-bit code words at the tail, drops a variable number of
// bytes from the head on pop, presents the head bytes to the decoder
// ==========================================================================

`include "thor_defs.svh"

module insn_window import thor_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       word_wr,  // Write strobe, one word per cycle
	input  code_word_t word,
	output logic       full,     // Level, writer holds off
	insn_win_if.queue  win
);

localparam int QB = `THOR_QUEUE_BYTES;
localparam int WB = `THOR_WINDOW_BYTES;

logic [7:0]   q [QB];    // Byte store, head at index 0
byte_count_t  count;     // Valid bytes in q
byte_count_t  pop_cnt;   // Bytes removed this edge
byte_count_t  keep_cnt;  // Bytes surviving the pop
logic         wr_ok;     // Write actually taken
insn_window_t win_bytes;

// ==========================================================================
// Fill level
// ==========================================================================

assign pop_cnt  = win.pop ? byte_count_t'(win.pop_len) : '0;
assign keep_cnt = count - pop_cnt;

// No room for one more word above 60 bytes
assign full  = count > byte_count_t'(QB - 4);
assign wr_ok = word_wr & ~full;  // Write while full is dropped

always_ff @(posedge clk) begin
	if (rst)
		count <= '0;
	else
		count <= keep_cnt + (wr_ok ? byte_count_t'(4) : '0);  // Pop and write both apply
end

// ==========================================================================
// Byte store
// ==========================================================================

// Every slot either takes a new word byte at the post-pop tail
// or moves down by the pop length
always_ff @(posedge clk) begin
	for (int i = 0; i < QB; i++) begin
		if (wr_ok && i >= int'(keep_cnt) && i < int'(keep_cnt) + 4)
			q[i] <= word[8*(i - int'(keep_cnt)) +: 8];   // Little-endian
		else if (i + int'(pop_cnt) < QB)
			q[i] <= q[i + int'(pop_cnt)];
		// Top slots past the shift keep stale bytes beyond count
	end
end

// ==========================================================================
// Head window
// ==========================================================================

always_comb begin
	for (int i = 0; i < WB; i++)
		win_bytes[8*i +: 8] = q[i];  // Byte 0 is the opcode
end

assign win.window = win_bytes;
assign win.count  = count;

endmodule

// File: design/imm_dec_if.sv
// ==========================================================================
// Decode result link
// Immediates and instruction length from decoder to issue stage
// ==========================================================================

interface imm_dec_if import thor_pkg::*; ();

	imm_t      imma;
	imm_t      immb;
	imm_t      immc;
	imm_t      immd;
	insn_len_t len;  // Total bytes incl. trailing prefix

	modport decoder (
		output imma, immb, immc, immd,
		output len
	);

	modport issuer (
		input  imma, immb, immc, immd,
		input  len
	);

endinterface

// File: design/insn_win_if.sv
// ==========================================================================
// Byte window link
// Queue head and fill level out, pop request and pop length back
// ==========================================================================

interface insn_win_if import thor_pkg::*; ();

	insn_window_t window;  // Lowest queue bytes
	byte_count_t  count;   // Valid bytes held
	logic         pop;     // One cycle per issued instruction
	insn_len_t    pop_len; // Bytes leaving the head on pop

	// Byte queue side
	modport queue (
		output window,
		output count,
		input  pop,
		input  pop_len
	);

	// Decoder and issue side, decoder only reads window
	modport user (
		input  window,
		input  count,
		output pop,
		output pop_len
	);

endinterface

// File: design/thor_pkg.sv
// ==========================================================================
// Immediate decode types
// Vector types for code words, the head window, immediates and counters
// ==========================================================================

package thor_pkg;

`include "thor_defs.svh"

// One fetched code word, byte 0 in bits 7:0
typedef logic [31:0] code_word_t;

// Head of the byte queue, opcode in byte 0
typedef logic [`THOR_WINDOW_BYTES*8-1:0] insn_window_t;

// Single immediate slot
typedef logic [`THOR_IMM_WID-1:0] imm_t;

typedef logic [5:0] insn_len_t;    // Length in bytes, base plus prefix
typedef logic [6:0] byte_count_t;  // Queue fill, 0 to 64
typedef logic [15:0] stream_ofs_t; // Byte position in the stream

// First byte of an instruction or a prefix
typedef logic [7:0] opcode_t;

endpackage

// File: design/thor_defs.svh
// ==========================================================================
// Immediate decode slice parameters
// Sizes shared by the byte queue, the decoder and the issue stage
// ==========================================================================

`ifndef THOR_DEFS_SVH
`define THOR_DEFS_SVH

// Width of each decoded immediate
`define THOR_IMM_WID      32

// Byte capacity of the instruction queue
`define THOR_QUEUE_BYTES  64

// Head bytes seen by the decoder, longest base form fits here
`define THOR_WINDOW_BYTES 32

`endif
